// File: Bender.yml
package:
  name: rackctl

sources:
  - rackctl_pkg.sv
  - flag_sync.sv
  - rackctl_wb_bridge.sv
  - rackctl_phy.sv
  - rackctl_top.sv
  - target: test
    files:
      - tb_rack_target.sv
      - tb_rackctl_top.sv

// File: files.f
rackctl_pkg.sv
flag_sync.sv
rackctl_wb_bridge.sv
rackctl_phy.sv
rackctl_top.sv
tb_rack_target.sv
tb_rackctl_top.sv

// File: flag_sync.sv
`default_nettype none

module flag_sync (
    input  wire logic clk_a_i,
    input  wire logic clk_b_i,
    input  wire logic rst_n_i,
    input  wire logic flag_a_i,
    output logic      flag_b_o
);

    // level that flips once per source pulse
    logic       toggle_a_q;
    // destination chain, bit 0 is the metastability catcher
    logic [2:0] sync_b_q;

    always_ff @(posedge clk_a_i) begin
        if (!rst_n_i) begin
            toggle_a_q <= 1'b0;
        end else if (flag_a_i) begin
            toggle_a_q <= ~toggle_a_q;
        end
    end

    always_ff @(posedge clk_b_i) begin
        if (!rst_n_i) begin
            sync_b_q <= '0;
        end else begin
            sync_b_q <= {sync_b_q[1:0], toggle_a_q};
        end
    end

    // any change of the synchronized level is one event
    assign flag_b_o = sync_b_q[2] ^ sync_b_q[1];

endmodule

`default_nettype wire

// File: rackctl_phy.sv
`default_nettype none

module rackctl_phy (
    input  wire logic                              sysclk_i,
    input  wire logic                              rst_n_i,
    input  wire rackctl_pkg::rackctl_txn_t         txn_i,
    input  wire logic                              start_i,
    output logic                                   done_o,
    output logic                                   err_o,
    output logic [rackctl_pkg::WB_DATA_W-1:0]      resp_data_o,
    output logic                                   rackctl_tx_o,
    input  wire logic                              rackctl_rx_i
);

    logic [1:0]                                                  rst_sync_q;
    logic                                                        rst_n_sys;
    rackctl_pkg::phy_state_t                                     state_q;
    logic [rackctl_pkg::FRAME_ADDR_W+rackctl_pkg::WB_DATA_W-1:0] tx_sr_q;
    logic [rackctl_pkg::BIT_CNT_W-1:0]                           bit_cnt_q;
    logic [rackctl_pkg::TIMER_W-1:0]                             timer_q;
    logic [rackctl_pkg::WB_DATA_W-1:0]                           rx_sr_q;
    logic [rackctl_pkg::FRAME_ADDR_W-1:0]                        addr_field;
    logic                                                        tx_q;
    logic                                                        rx_q;
    logic                                                        done_q;
    logic                                                        err_q;

    // bring the wishbone-side reset into sysclk
    always_ff @(posedge sysclk_i) begin
        rst_sync_q <= {rst_sync_q[0], rst_n_i};
    end
    assign rst_n_sys = rst_sync_q[1];

    // read flag on top, bit 22 spare
    assign addr_field = {txn_i.rnw, 1'b0, txn_i.addr};

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_sys) begin
            rx_q <= 1'b1;
        end else begin
            rx_q <= rackctl_rx_i;
        end
    end

    always_ff @(posedge sysclk_i) begin
        if (!rst_n_sys) begin
            state_q   <= rackctl_pkg::PHY_IDLE;
            tx_q      <= 1'b1;
            bit_cnt_q <= '0;
            timer_q   <= '0;
            done_q    <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            err_q  <= 1'b0;
            case (state_q)
                rackctl_pkg::PHY_IDLE: begin
                    tx_q <= 1'b1;
                    if (start_i) begin
                        // start bit goes out right away
                        tx_q      <= 1'b0;
                        bit_cnt_q <= txn_i.rnw ?
                            rackctl_pkg::BIT_CNT_W'(rackctl_pkg::FRAME_ADDR_W) :
                            rackctl_pkg::BIT_CNT_W'(rackctl_pkg::FRAME_ADDR_W +
                                                    rackctl_pkg::WB_DATA_W);
                        state_q   <= rackctl_pkg::PHY_SEND;
                    end
                end
                rackctl_pkg::PHY_SEND: begin
                    if (bit_cnt_q != '0) begin
                        tx_q      <= tx_sr_q[$high(tx_sr_q)];
                        bit_cnt_q <= bit_cnt_q - 1'b1;
                    end else begin
                        tx_q    <= 1'b1;
                        timer_q <= '0;
                        state_q <= rackctl_pkg::PHY_WAIT_RESP;
                    end
                end
                rackctl_pkg::PHY_WAIT_RESP: begin
                    if (!rx_q) begin
                        // writes are answered by the start bit alone
                        if (txn_i.rnw) begin
                            bit_cnt_q <= rackctl_pkg::BIT_CNT_W'(rackctl_pkg::WB_DATA_W);
                            state_q   <= rackctl_pkg::PHY_RECV;
                        end else begin
                            done_q  <= 1'b1;
                            state_q <= rackctl_pkg::PHY_DONE;
                        end
                    end else if (timer_q ==
                                 rackctl_pkg::TIMER_W'(rackctl_pkg::RESP_TIMEOUT)) begin
                        err_q   <= 1'b1;
                        state_q <= rackctl_pkg::PHY_DONE;
                    end else begin
                        timer_q <= timer_q + 1'b1;
                    end
                end
                rackctl_pkg::PHY_RECV: begin
                    bit_cnt_q <= bit_cnt_q - 1'b1;
                    if (bit_cnt_q == rackctl_pkg::BIT_CNT_W'(1)) begin
                        done_q  <= 1'b1;
                        state_q <= rackctl_pkg::PHY_DONE;
                    end
                end
                rackctl_pkg::PHY_DONE: begin
                    state_q <= rackctl_pkg::PHY_IDLE;
                end
                default: begin
                    state_q <= rackctl_pkg::PHY_IDLE;
                end
            endcase
        end
    end

    // frame payload, msb first
    always_ff @(posedge sysclk_i) begin
        if (state_q == rackctl_pkg::PHY_IDLE && start_i) begin
            tx_sr_q <= {addr_field, txn_i.data};
        end else if (state_q == rackctl_pkg::PHY_SEND) begin
            tx_sr_q <= tx_sr_q << 1;
        end
    end

    // response data, left alone until the next read
    always_ff @(posedge sysclk_i) begin
        if (state_q == rackctl_pkg::PHY_RECV) begin
            rx_sr_q <= {rx_sr_q[rackctl_pkg::WB_DATA_W-2:0], rx_q};
        end
    end

    assign rackctl_tx_o = tx_q;
    assign done_o       = done_q;
    assign err_o        = err_q;
    assign resp_data_o  = rx_sr_q;

    a_done_err_excl: assert property (@(posedge sysclk_i) disable iff (!rst_n_sys)
        !(done_o && err_o));

endmodule

`default_nettype wire

// File: rackctl_pkg.sv
`default_nettype none

package rackctl_pkg;

    localparam int WB_ADDR_W = 22;
    localparam int WB_DATA_W = 32;
    // read flag, one spare zero bit, then the wishbone address
    localparam int FRAME_ADDR_W = 24;
    // sysclk cycles allowed between the last frame bit and the response start bit
    localparam int RESP_TIMEOUT = 64;
    localparam logic [WB_DATA_W-1:0] ERR_DATA = '1;

    // counter widths inside the link engine
    localparam int BIT_CNT_W = $clog2(FRAME_ADDR_W + WB_DATA_W + 1);
    localparam int TIMER_W = $clog2(RESP_TIMEOUT + 1);

    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [WB_ADDR_W-1:0] adr;
        logic [WB_DATA_W-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [WB_DATA_W-1:0] dat;
    } wb_rsp_t;

    // one transaction in flight, shared across the clock crossing
    typedef struct packed {
        logic                 rnw;
        logic [WB_ADDR_W-1:0] addr;
        logic [WB_DATA_W-1:0] data;
    } rackctl_txn_t;

    typedef enum logic [2:0] {
        BR_IDLE,
        BR_ACCEPT,
        BR_ISSUE,
        BR_WAIT_COMPLETE,
        BR_ACK
    } bridge_state_t;

    typedef enum logic [2:0] {
        PHY_IDLE,
        PHY_SEND,
        PHY_WAIT_RESP,
        PHY_RECV,
        PHY_DONE
    } phy_state_t;

    typedef enum logic {
        DBG,
        GTP
    } master_t;

endpackage

`default_nettype wire

// File: rackctl_top.sv
`default_nettype none

module rackctl_top (
    input  wire logic                 wb_clk_i,
    input  wire logic                 rst_n_i,
    input  wire logic                 sysclk_i,
    input  wire logic                 sysclk_ok_i,
    input  wire rackctl_pkg::wb_req_t gtp_req_i,
    input  wire rackctl_pkg::wb_req_t dbg_req_i,
    output rackctl_pkg::wb_rsp_t      gtp_rsp_o,
    output rackctl_pkg::wb_rsp_t      dbg_rsp_o,
    input  wire logic                 err_rst_i,
    output logic                      bridge_err_o,
    output logic                      rackctl_tx_o,
    input  wire logic                 rackctl_rx_i
);

    rackctl_pkg::rackctl_txn_t         txn;
    logic [rackctl_pkg::WB_DATA_W-1:0] resp_data;
    // start goes wb -> sys, done and err come back
    logic                              start_wb;
    logic                              start_sys;
    logic                              done_sys;
    logic                              done_wb;
    logic                              err_sys;
    logic                              err_wb;

    rackctl_wb_bridge u_bridge (
        .wb_clk_i     (wb_clk_i),
        .rst_n_i      (rst_n_i),
        .sysclk_ok_i  (sysclk_ok_i),
        .gtp_req_i    (gtp_req_i),
        .dbg_req_i    (dbg_req_i),
        .gtp_rsp_o    (gtp_rsp_o),
        .dbg_rsp_o    (dbg_rsp_o),
        .err_rst_i    (err_rst_i),
        .bridge_err_o (bridge_err_o),
        .txn_o        (txn),
        .start_o      (start_wb),
        .done_i       (done_wb),
        .err_i        (err_wb),
        .resp_data_i  (resp_data)
    );

    flag_sync u_start_sync (
        .clk_a_i  (wb_clk_i),
        .clk_b_i  (sysclk_i),
        .rst_n_i  (rst_n_i),
        .flag_a_i (start_wb),
        .flag_b_o (start_sys)
    );

    flag_sync u_done_sync (
        .clk_a_i  (sysclk_i),
        .clk_b_i  (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .flag_a_i (done_sys),
        .flag_b_o (done_wb)
    );

    flag_sync u_err_sync (
        .clk_a_i  (sysclk_i),
        .clk_b_i  (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .flag_a_i (err_sys),
        .flag_b_o (err_wb)
    );

    rackctl_phy u_phy (
        .sysclk_i     (sysclk_i),
        .rst_n_i      (rst_n_i),
        .txn_i        (txn),
        .start_i      (start_sys),
        .done_o       (done_sys),
        .err_o        (err_sys),
        .resp_data_o  (resp_data),
        .rackctl_tx_o (rackctl_tx_o),
        .rackctl_rx_i (rackctl_rx_i)
    );

endmodule

`default_nettype wire

// File: rackctl_wb_bridge.sv
`default_nettype none

module rackctl_wb_bridge (
    input  wire logic                                 wb_clk_i,
    input  wire logic                                 rst_n_i,
    input  wire logic                                 sysclk_ok_i,
    input  wire rackctl_pkg::wb_req_t                 gtp_req_i,
    input  wire rackctl_pkg::wb_req_t                 dbg_req_i,
    output rackctl_pkg::wb_rsp_t                      gtp_rsp_o,
    output rackctl_pkg::wb_rsp_t                      dbg_rsp_o,
    input  wire logic                                 err_rst_i,
    output logic                                      bridge_err_o,
    output rackctl_pkg::rackctl_txn_t                 txn_o,
    output logic                                      start_o,
    input  wire logic                                 done_i,
    input  wire logic                                 err_i,
    input  wire logic [rackctl_pkg::WB_DATA_W-1:0]    resp_data_i
);

    rackctl_pkg::bridge_state_t state_q;
    rackctl_pkg::master_t       master_q;
    rackctl_pkg::rackctl_txn_t  txn_q;
    rackctl_pkg::wb_req_t       sel_req;
    logic                       gtp_valid;
    logic                       dbg_valid;
    logic                       start_q;
    logic                       err_q;

    // a master only counts with cyc and stb both up
    assign gtp_valid = gtp_req_i.cyc && gtp_req_i.stb;
    assign dbg_valid = dbg_req_i.cyc && dbg_req_i.stb;

    // master_q is already valid when ACCEPT reads this mux
    assign sel_req = (master_q == rackctl_pkg::GTP) ? gtp_req_i : dbg_req_i;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state_q  <= rackctl_pkg::BR_IDLE;
            master_q <= rackctl_pkg::DBG;
            start_q  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            case (state_q)
                rackctl_pkg::BR_IDLE: begin
                    // no new work while the link clock is down
                    if (sysclk_ok_i && (gtp_valid || dbg_valid)) begin
                        master_q <= gtp_valid ? rackctl_pkg::GTP : rackctl_pkg::DBG;
                        state_q  <= rackctl_pkg::BR_ACCEPT;
                    end
                end
                rackctl_pkg::BR_ACCEPT: begin
                    // start pulse lines up with the ISSUE cycle
                    start_q <= 1'b1;
                    state_q <= rackctl_pkg::BR_ISSUE;
                end
                rackctl_pkg::BR_ISSUE: begin
                    state_q <= rackctl_pkg::BR_WAIT_COMPLETE;
                end
                rackctl_pkg::BR_WAIT_COMPLETE: begin
                    if (done_i || err_i) begin
                        state_q <= rackctl_pkg::BR_ACK;
                    end
                end
                rackctl_pkg::BR_ACK: begin
                    state_q <= rackctl_pkg::BR_IDLE;
                end
                default: begin
                    state_q <= rackctl_pkg::BR_IDLE;
                end
            endcase
        end
    end

    // transaction register, also holds the read data for the ack
    always_ff @(posedge wb_clk_i) begin
        if (state_q == rackctl_pkg::BR_ACCEPT) begin
            txn_q.rnw  <= !sel_req.we;
            txn_q.addr <= sel_req.adr;
            if (sel_req.we) begin
                txn_q.data <= sel_req.dat;
            end
        end else if (state_q == rackctl_pkg::BR_WAIT_COMPLETE) begin
            if (done_i) begin
                if (txn_q.rnw) begin
                    txn_q.data <= resp_data_i;
                end
            end else if (err_i) begin
                txn_q.data <= rackctl_pkg::ERR_DATA;
            end
        end
    end

    // sticky until software clears it
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            err_q <= 1'b0;
        end else if (state_q == rackctl_pkg::BR_WAIT_COMPLETE && err_i && !done_i) begin
            err_q <= 1'b1;
        end else if (err_rst_i) begin
            err_q <= 1'b0;
        end
    end

    always_comb begin
        gtp_rsp_o.ack = (state_q == rackctl_pkg::BR_ACK) && (master_q == rackctl_pkg::GTP);
        gtp_rsp_o.dat = txn_q.data;
        dbg_rsp_o.ack = (state_q == rackctl_pkg::BR_ACK) && (master_q == rackctl_pkg::DBG);
        dbg_rsp_o.dat = txn_q.data;
    end

    assign txn_o        = txn_q;
    assign start_o      = start_q;
    assign bridge_err_o = err_q;

    a_ack_onehot: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        !(gtp_rsp_o.ack && dbg_rsp_o.ack));

    // the phy samples txn_o across the crossing, so it must hold still
    a_txn_stable: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        (state_q == rackctl_pkg::BR_WAIT_COMPLETE) |=>
            (state_q != rackctl_pkg::BR_WAIT_COMPLETE) || $stable(txn_o));

    a_start_in_issue: assert property (@(posedge wb_clk_i) disable iff (!rst_n_i)
        start_o |-> (state_q == rackctl_pkg::BR_ISSUE));

endmodule

`default_nettype wire

// File: tb_rack_target.sv
`default_nettype none

module tb_rack_target (
    input  wire logic sysclk_i,
    input  wire logic silent_i,
    input  wire logic tx_i,
    output logic      rx_o,
    output int        bad_frames_o
);

    // remote register space, unwritten locations read as zero
    logic [rackctl_pkg::WB_DATA_W-1:0] mem [logic [rackctl_pkg::WB_ADDR_W-1:0]];

    // called once the start bit has been seen on the line
    task automatic answer_frame();
        logic [rackctl_pkg::FRAME_ADDR_W-1:0] addr_field;
        logic [rackctl_pkg::WB_ADDR_W-1:0]    addr;
        logic [rackctl_pkg::WB_DATA_W-1:0]    data;
        logic                                 rnw;
        int unsigned                          delay;
        int                                   i;
        for (i = rackctl_pkg::FRAME_ADDR_W - 1; i >= 0; i--) begin
            @(negedge sysclk_i);
            addr_field[i] = tx_i;
        end
        rnw  = addr_field[rackctl_pkg::FRAME_ADDR_W-1];
        addr = addr_field[rackctl_pkg::WB_ADDR_W-1:0];
        // spare bit between read flag and address must be zero
        if (addr_field[rackctl_pkg::WB_ADDR_W] !== 1'b0) begin
            bad_frames_o++;
        end
        if (!rnw) begin
            for (i = rackctl_pkg::WB_DATA_W - 1; i >= 0; i--) begin
                @(negedge sysclk_i);
                data[i] = tx_i;
            end
        end
        // a silenced remote neither stores nor answers
        if (!silent_i) begin
            if (!rnw) begin
                mem[addr] = data;
            end else begin
                data = mem.exists(addr) ? mem[addr] : '0;
            end
            // answer well inside the response window
            delay = 1 + $urandom_range(rackctl_pkg::RESP_TIMEOUT - 16);
            repeat (delay) @(posedge sysclk_i);
            #1 rx_o = 1'b0;
            if (rnw) begin
                for (i = rackctl_pkg::WB_DATA_W - 1; i >= 0; i--) begin
                    @(posedge sysclk_i);
                    #1 rx_o = data[i];
                end
            end
            @(posedge sysclk_i);
            #1 rx_o = 1'b1;
        end
    endtask

    initial begin
        rx_o = 1'b1;
        bad_frames_o = 0;
        forever begin
            // hunt for a start bit in the middle of each bit period
            @(negedge sysclk_i);
            if (tx_i === 1'b0) begin
                answer_frame();
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_rackctl_top.sv
`default_nettype none

module tb_rackctl_top;

    localparam int          NUM_TXN     = 200;
    localparam int          CYCLE_LIMIT = 300 * NUM_TXN + 1000;
    localparam int          POOL_SIZE   = 16;
    localparam logic [31:0] SEED        = 32'hc24671c7;

    logic                 wb_clk;
    logic                 sysclk;
    logic                 rst_n;
    logic                 sysclk_ok;
    logic                 err_rst;
    logic                 silent;
    rackctl_pkg::wb_req_t gtp_req;
    rackctl_pkg::wb_req_t dbg_req;
    rackctl_pkg::wb_rsp_t gtp_rsp;
    rackctl_pkg::wb_rsp_t dbg_rsp;
    logic                 bridge_err;
    logic                 tx;
    logic                 rx;
    int                   bad_frames;
    int                   cycle_cnt = 0;
    int                   errors = 0;
    int                   checks = 0;
    int                   gtp_reqs = 0;
    int                   gtp_acks = 0;
    int                   dbg_reqs = 0;
    int                   dbg_acks = 0;
    int                   gtp_ack_cycle;
    int                   dbg_ack_cycle;
    logic [31:0]          model_mem [logic [21:0]];
    logic [21:0]          addr_pool [POOL_SIZE];

    rackctl_top i_dut (
        .wb_clk_i     (wb_clk),
        .rst_n_i      (rst_n),
        .sysclk_i     (sysclk),
        .sysclk_ok_i  (sysclk_ok),
        .gtp_req_i    (gtp_req),
        .dbg_req_i    (dbg_req),
        .gtp_rsp_o    (gtp_rsp),
        .dbg_rsp_o    (dbg_rsp),
        .err_rst_i    (err_rst),
        .bridge_err_o (bridge_err),
        .rackctl_tx_o (tx),
        .rackctl_rx_i (rx)
    );

    tb_rack_target i_target (
        .sysclk_i     (sysclk),
        .silent_i     (silent),
        .tx_i         (tx),
        .rx_o         (rx),
        .bad_frames_o (bad_frames)
    );

    initial begin
        wb_clk = 1'b0;
        forever #10 wb_clk = ~wb_clk;
    end

    // link clock, unrelated to the wishbone clock
    initial begin
        sysclk = 1'b0;
        forever #7 sysclk = ~sysclk;
    end

    initial begin
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge wb_clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d wb clock cycles", CYCLE_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ack bookkeeping, sampled mid-cycle
    always @(negedge wb_clk) begin
        if (gtp_rsp.ack && dbg_rsp.ack) begin
            errors++;
            $display("both acks were high together at t=%0t", $time);
        end
        if (gtp_rsp.ack === 1'b1) begin
            gtp_acks++;
        end
        if (dbg_rsp.ack === 1'b1) begin
            dbg_acks++;
        end
    end

    function automatic logic [31:0] model_read(input logic [21:0] adr);
        if (model_mem.exists(adr)) begin
            return model_mem[adr];
        end
        return '0;
    endfunction

    task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        errors++;
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, sig, exp_val, got_val);
    endtask

    // one classic wishbone cycle on the chosen master
    task automatic wb_transfer(input logic use_gtp, input logic we, input logic [21:0] adr,
                               input logic [31:0] wdat, output logic [31:0] rdat);
        rackctl_pkg::wb_req_t req;
        logic                 acked;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr = adr;
        // read cycles carry junk on dat
        req.dat = we ? wdat : $urandom();
        acked   = 1'b0;
        @(posedge wb_clk);
        #2;
        if (use_gtp) begin
            gtp_req = req;
            gtp_reqs++;
        end else begin
            dbg_req = req;
            dbg_reqs++;
        end
        while (!acked) begin
            @(negedge wb_clk);
            acked = use_gtp ? gtp_rsp.ack : dbg_rsp.ack;
        end
        if (use_gtp) begin
            rdat = gtp_rsp.dat;
            gtp_ack_cycle = cycle_cnt;
        end else begin
            rdat = dbg_rsp.dat;
            dbg_ack_cycle = cycle_cnt;
        end
        @(posedge wb_clk);
        #2;
        if (use_gtp) begin
            gtp_req = '0;
        end else begin
            dbg_req = '0;
        end
    endtask

    task automatic run_and_check(input logic use_gtp, input logic we, input logic [21:0] adr,
                                 input logic [31:0] wdat, input logic expect_err);
        logic [31:0] rdat;
        logic [31:0] exp_dat;
        wb_transfer(use_gtp, we, adr, wdat, rdat);
        if (expect_err) begin
            exp_dat = rackctl_pkg::ERR_DATA;
        end else if (we) begin
            exp_dat = wdat;
            model_mem[adr] = wdat;
        end else begin
            exp_dat = model_read(adr);
        end
        checks++;
        if (rdat !== exp_dat) begin
            report_mismatch(use_gtp ? "gtp_rsp_o.dat" : "dbg_rsp_o.dat", exp_dat, rdat);
        end
    endtask

    task automatic random_op();
        run_and_check(1'($urandom_range(1)), 1'($urandom_range(1)),
                      addr_pool[$urandom_range(POOL_SIZE - 1)], $urandom(), 1'b0);
    endtask

    task automatic check_err_flag(input logic exp_val);
        @(negedge wb_clk);
        checks++;
        if (bridge_err !== exp_val) begin
            report_mismatch("bridge_err_o", 32'(exp_val), 32'(bridge_err));
        end
    endtask

    initial begin
        logic [21:0] adr;
        logic [31:0] wd;
        int          i;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        sysclk_ok = 1'b1;
        err_rst   = 1'b0;
        silent    = 1'b0;
        gtp_req   = '0;
        dbg_req   = '0;
        for (i = 0; i < POOL_SIZE; i++) begin
            addr_pool[i] = 22'($urandom());
        end
        repeat (5) @(posedge wb_clk);
        #2 rst_n = 1'b1;

        // quiet outputs after reset
        repeat (4) begin
            @(negedge wb_clk);
            checks++;
            if (gtp_rsp.ack !== 1'b0 || dbg_rsp.ack !== 1'b0) begin
                report_mismatch("ack", 32'h0, {30'h0, gtp_rsp.ack, dbg_rsp.ack});
            end
            if (bridge_err !== 1'b0) begin
                report_mismatch("bridge_err_o", 32'h0, 32'(bridge_err));
            end
            if (tx !== 1'b1) begin
                report_mismatch("rackctl_tx_o", 32'h1, 32'(tx));
            end
        end

        // writes then read-back, plus never written locations
        for (i = 0; i < 60; i++) begin
            run_and_check(1'($urandom_range(1)), 1'b1,
                          addr_pool[$urandom_range(POOL_SIZE - 1)], $urandom(), 1'b0);
        end
        for (i = 0; i < POOL_SIZE; i++) begin
            run_and_check(1'($urandom_range(1)), 1'b0, addr_pool[i], '0, 1'b0);
        end
        for (i = 0; i < 4; i++) begin
            do begin
                adr = 22'($urandom());
            end while (model_mem.exists(adr));
            run_and_check(1'($urandom_range(1)), 1'b0, adr, '0, 1'b0);
        end

        // both masters in the same cycle, gtp has priority
        for (i = 0; i < 10; i++) begin
            fork
                run_and_check(1'b1, 1'($urandom_range(1)),
                              addr_pool[$urandom_range(POOL_SIZE - 1)], $urandom(), 1'b0);
                run_and_check(1'b0, 1'($urandom_range(1)),
                              addr_pool[$urandom_range(POOL_SIZE - 1)], $urandom(), 1'b0);
            join
            checks++;
            if (gtp_ack_cycle >= dbg_ack_cycle) begin
                errors++;
                $display("gtp was not acknowledged before dbg in round %0d", i);
            end
        end

        // silent remote gives timeouts and a sticky error
        @(posedge wb_clk);
        #2 silent = 1'b1;
        run_and_check(1'b1, 1'b0, addr_pool[0], '0, 1'b1);
        run_and_check(1'b0, 1'b1, addr_pool[1], $urandom(), 1'b1);
        check_err_flag(1'b1);
        @(posedge wb_clk);
        #2 silent = 1'b0;
        repeat (10) begin
            random_op();
            check_err_flag(1'b1);
        end
        @(posedge wb_clk);
        #2 err_rst = 1'b1;
        @(posedge wb_clk);
        #2 err_rst = 1'b0;
        check_err_flag(1'b0);
        random_op();
        check_err_flag(1'b0);

        // link clock not ready, request must wait
        for (i = 0; i < 2; i++) begin
            @(posedge wb_clk);
            #2 sysclk_ok = 1'b0;
            wd = $urandom();
            fork
                run_and_check(1'($urandom_range(1)), (i == 0), addr_pool[2], wd, 1'b0);
                begin
                    repeat (40) begin
                        @(negedge wb_clk);
                        if (gtp_rsp.ack || dbg_rsp.ack) begin
                            errors++;
                            $display("ack arrived while sysclk_ok_i was low at t=%0t", $time);
                        end
                        if (tx !== 1'b1) begin
                            report_mismatch("rackctl_tx_o", 32'h1, 32'(tx));
                        end
                    end
                    @(posedge wb_clk);
                    #2 sysclk_ok = 1'b1;
                end
            join
        end

        // random mix to finish
        repeat (60) begin
            random_op();
        end

        if (gtp_acks != gtp_reqs || dbg_acks != dbg_reqs) begin
            errors++;
            $display("ack count differs from request count: gtp %0d/%0d, dbg %0d/%0d",
                     gtp_acks, gtp_reqs, dbg_acks, dbg_reqs);
        end
        if (bad_frames != 0) begin
            errors++;
            $display("remote end saw %0d frames with a nonzero spare bit", bad_frames);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
